//--- hw/cell_array_pkg.sv
package cell_array_pkg;

    ////////////////////
    // Data widths
    ////////////////////

    // Handles, indices, values, metadata, ranks, codes and counts
    typedef logic [7:0] word_t;

    // Broadcast opcode
    typedef logic [2:0] op_t;

    ////////////////////
    // Opcodes
    ////////////////////

    localparam op_t OP_UPDATE       = 3'd0;
    localparam op_t OP_LOOKUP       = 3'd1;
    localparam op_t OP_ENCODE       = 3'd2;
    localparam op_t OP_CONGRUE_UP   = 3'd3;
    localparam op_t OP_CONGRUE_DOWN = 3'd4;
    localparam op_t OP_MARK_FREE    = 3'd5;
    localparam op_t OP_ENRANK       = 3'd6;
    localparam op_t OP_DEBUG        = 3'd7;

    // Sequencer FSM
    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_SETTLE,
        S_CAPTURE
    } seq_state_t;

endpackage

//--- hw/memory_cell.sv
`timescale 1ns/1ps

module memory_cell #(
    parameter cell_array_pkg::word_t HANDLE = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  cell_array_pkg::op_t   cmd_op,
    input  cell_array_pkg::word_t cmd_index,
    input  cell_array_pkg::word_t cmd_value,
    input  cell_array_pkg::word_t cmd_metadata,
    input  logic                  cmd_meta_valid,
    output logic                  hit,
    output cell_array_pkg::word_t res_value,
    output cell_array_pkg::word_t res_context
);

    ////////////////////
    // Cell state
    ////////////////////

    logic                  arr_def;
    logic                  elt_def;
    cell_array_pkg::word_t array_code;
    cell_array_pkg::word_t rank;
    cell_array_pkg::word_t low;
    cell_array_pkg::word_t high;
    cell_array_pkg::word_t index;
    cell_array_pkg::word_t value;

    logic                  arr_def_next;
    logic                  elt_def_next;
    cell_array_pkg::word_t array_code_next;
    cell_array_pkg::word_t rank_next;
    cell_array_pkg::word_t low_next;
    cell_array_pkg::word_t high_next;
    cell_array_pkg::word_t index_next;
    cell_array_pkg::word_t value_next;

    logic                  hit_next;
    cell_array_pkg::word_t res_value_next;
    cell_array_pkg::word_t res_context_next;

    // Metadata addresses this cell
    logic owner;
    // Metadata falls inside the element range
    logic in_range;

    assign owner    = (cmd_metadata == HANDLE);
    assign in_range = (low <= cmd_metadata) && (cmd_metadata <= high);

    ////////////////////
    // Next state per opcode
    ////////////////////

    always_comb begin
        arr_def_next     = arr_def;
        elt_def_next     = elt_def;
        array_code_next  = array_code;
        rank_next        = rank;
        low_next         = low;
        high_next        = high;
        index_next       = index;
        value_next       = value;
        hit_next         = hit;
        res_value_next   = res_value;
        res_context_next = res_context;

        case (cmd_op)
            cell_array_pkg::OP_UPDATE: begin
                hit_next         = owner && cmd_meta_valid;
                res_value_next   = HANDLE;
                res_context_next = HANDLE;
                if (owner && cmd_meta_valid) begin
                    arr_def_next    = 1'b1;
                    elt_def_next    = 1'b1;
                    array_code_next = HANDLE;
                    low_next        = HANDLE;
                    high_next       = HANDLE;
                    index_next      = cmd_index;
                    value_next      = cmd_value;
                    rank_next       = 8'd1;
                end
            end

            cell_array_pkg::OP_LOOKUP: begin
                hit_next         = (index == cmd_index) && in_range && cmd_meta_valid;
                res_value_next   = value;
                res_context_next = rank;
            end

            cell_array_pkg::OP_ENCODE: begin
                hit_next         = cmd_meta_valid && arr_def && owner;
                res_value_next   = array_code;
                res_context_next = array_code;
            end

            cell_array_pkg::OP_CONGRUE_UP: begin
                if (cmd_index == HANDLE && cmd_meta_valid) begin
                    array_code_next = cmd_metadata + 8'd1;
                    low_next        = cmd_metadata + 8'd1;
                    high_next       = cmd_metadata + 8'd1;
                    rank_next       = cmd_value + 8'd1;
                end else if (cmd_meta_valid) begin
                    if (arr_def && array_code > cmd_metadata)
                        array_code_next = array_code + 8'd1;
                    if (elt_def && low > cmd_metadata)
                        low_next = low + 8'd1;
                    if (elt_def && high >= cmd_metadata)
                        high_next = high + 8'd1;
                end
            end

            cell_array_pkg::OP_CONGRUE_DOWN: begin
                if (cmd_index == HANDLE && cmd_meta_valid) begin
                    arr_def_next = 1'b0;
                    rank_next    = '0;
                end
                if (elt_def && cmd_meta_valid) begin
                    if (cmd_metadata < low) begin
                        low_next  = low - 8'd1;
                        high_next = high - 8'd1;
                    end else if (in_range) begin
                        high_next = high - 8'd1;
                    end
                end
                // Empty range frees the cell
                if (elt_def && low_next > high_next) begin
                    elt_def_next = 1'b0;
                    arr_def_next = 1'b0;
                end
                if (arr_def && cmd_meta_valid && array_code > cmd_metadata)
                    array_code_next = array_code - 8'd1;
            end

            cell_array_pkg::OP_MARK_FREE: begin
                hit_next         = !elt_def;
                res_value_next   = HANDLE;
                res_context_next = HANDLE;
            end

            cell_array_pkg::OP_ENRANK: begin
                hit_next         = cmd_meta_valid && arr_def && owner;
                res_value_next   = rank;
                res_context_next = rank;
            end

            cell_array_pkg::OP_DEBUG: begin
                hit_next       = owner;
                res_value_next = high + 8'd1;
            end
        endcase
    end

    // Only a broadcast strobe changes the cell
    always_ff @(posedge clk) begin
        if (!reset) begin
            arr_def     <= 1'b0;
            elt_def     <= 1'b0;
            array_code  <= '0;
            rank        <= '0;
            low         <= '0;
            high        <= '0;
            index       <= '0;
            value       <= '0;
            hit         <= 1'b0;
            res_value   <= '0;
            res_context <= '0;
        end else if (cmd_valid) begin
            arr_def     <= arr_def_next;
            elt_def     <= elt_def_next;
            array_code  <= array_code_next;
            rank        <= rank_next;
            low         <= low_next;
            high        <= high_next;
            index       <= index_next;
            value       <= value_next;
            hit         <= hit_next;
            res_value   <= res_value_next;
            res_context <= res_context_next;
        end
    end

endmodule

//--- hw/match_reduce.sv
`timescale 1ns/1ps

module match_reduce #(
    parameter int NUM_CELLS = 8
) (
    input  logic [NUM_CELLS-1:0]                                 hits,
    input  logic [NUM_CELLS*$bits(cell_array_pkg::word_t)-1:0]   res_values,
    input  logic [NUM_CELLS*$bits(cell_array_pkg::word_t)-1:0]   res_contexts,
    output logic                                                 red_any,
    output cell_array_pkg::word_t                                red_count,
    output cell_array_pkg::word_t                                red_handle,
    output cell_array_pkg::word_t                                red_value,
    output cell_array_pkg::word_t                                red_context
);

    localparam int W = $bits(cell_array_pkg::word_t);

    assign red_any = |hits;

    ////////////////////
    // Population count
    ////////////////////

    always_comb begin
        red_count = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            if (hits[i])
                red_count = red_count + 8'd1;
        end
    end

    ////////////////////
    // Priority select
    ////////////////////

    // Scan from the top so the lowest hit wins
    always_comb begin
        red_handle  = '0;
        red_value   = '0;
        red_context = '0;
        for (int i = NUM_CELLS - 1; i >= 0; i--) begin
            if (hits[i]) begin
                red_handle  = cell_array_pkg::word_t'(i);
                red_value   = res_values[i*W +: W];
                red_context = res_contexts[i*W +: W];
            end
        end
    end

endmodule

//--- hw/command_sequencer.sv
`timescale 1ns/1ps

module command_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  cell_array_pkg::op_t   op,
    input  cell_array_pkg::word_t index,
    input  cell_array_pkg::word_t value,
    input  cell_array_pkg::word_t metadata,
    input  logic                  meta_valid,
    output logic                  cmd_valid,
    output cell_array_pkg::op_t   cmd_op,
    output cell_array_pkg::word_t cmd_index,
    output cell_array_pkg::word_t cmd_value,
    output cell_array_pkg::word_t cmd_metadata,
    output logic                  cmd_meta_valid,
    input  logic                  red_any,
    input  cell_array_pkg::word_t red_count,
    input  cell_array_pkg::word_t red_handle,
    input  cell_array_pkg::word_t red_value,
    input  cell_array_pkg::word_t red_context,
    output logic                  busy,
    output logic                  done,
    output logic                  match_any,
    output cell_array_pkg::word_t match_count,
    output cell_array_pkg::word_t match_handle,
    output cell_array_pkg::word_t result_value,
    output cell_array_pkg::word_t result_context
);

    cell_array_pkg::seq_state_t state;
    logic                       accept;

    // Capture cycle is free for the next start
    assign accept = start && (state == cell_array_pkg::S_IDLE ||
                              state == cell_array_pkg::S_CAPTURE);

    assign cmd_valid = (state == cell_array_pkg::S_ISSUE);
    assign busy      = (state == cell_array_pkg::S_ISSUE) || (state == cell_array_pkg::S_SETTLE);
    assign done      = (state == cell_array_pkg::S_CAPTURE);

    ////////////////////
    // FSM and results
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            state          <= cell_array_pkg::S_IDLE;
            match_any      <= 1'b0;
            match_count    <= '0;
            match_handle   <= '0;
            result_value   <= '0;
            result_context <= '0;
        end else begin
            case (state)
                cell_array_pkg::S_ISSUE: state <= cell_array_pkg::S_SETTLE;
                cell_array_pkg::S_SETTLE: begin
                    state          <= cell_array_pkg::S_CAPTURE;
                    match_any      <= red_any;
                    match_count    <= red_count;
                    match_handle   <= red_handle;
                    result_value   <= red_value;
                    result_context <= red_context;
                end
                default: state <= accept ? cell_array_pkg::S_ISSUE : cell_array_pkg::S_IDLE;
            endcase
        end
    end

    // Command held for the broadcast
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_op         <= op;
            cmd_index      <= index;
            cmd_value      <= value;
            cmd_metadata   <= metadata;
            cmd_meta_valid <= meta_valid;
        end
    end

endmodule

//--- hw/cell_array_top.sv
`timescale 1ns/1ps

module cell_array_top #(
    parameter int NUM_CELLS = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  cell_array_pkg::op_t   op,
    input  cell_array_pkg::word_t index,
    input  cell_array_pkg::word_t value,
    input  cell_array_pkg::word_t metadata,
    input  logic                  meta_valid,
    output logic                  busy,
    output logic                  done,
    output logic                  match_any,
    output cell_array_pkg::word_t match_count,
    output cell_array_pkg::word_t match_handle,
    output cell_array_pkg::word_t result_value,
    output cell_array_pkg::word_t result_context
);

    localparam int W = $bits(cell_array_pkg::word_t);

    // Broadcast bus
    logic                  cmd_valid;
    cell_array_pkg::op_t   cmd_op;
    cell_array_pkg::word_t cmd_index;
    cell_array_pkg::word_t cmd_value;
    cell_array_pkg::word_t cmd_metadata;
    logic                  cmd_meta_valid;

    // Per-cell answers, flattened
    logic [NUM_CELLS-1:0]   hits;
    logic [NUM_CELLS*W-1:0] res_values;
    logic [NUM_CELLS*W-1:0] res_contexts;

    logic                  red_any;
    cell_array_pkg::word_t red_count;
    cell_array_pkg::word_t red_handle;
    cell_array_pkg::word_t red_value;
    cell_array_pkg::word_t red_context;

    command_sequencer seq_i (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .op             (op),
        .index          (index),
        .value          (value),
        .metadata       (metadata),
        .meta_valid     (meta_valid),
        .cmd_valid      (cmd_valid),
        .cmd_op         (cmd_op),
        .cmd_index      (cmd_index),
        .cmd_value      (cmd_value),
        .cmd_metadata   (cmd_metadata),
        .cmd_meta_valid (cmd_meta_valid),
        .red_any        (red_any),
        .red_count      (red_count),
        .red_handle     (red_handle),
        .red_value      (red_value),
        .red_context    (red_context),
        .busy           (busy),
        .done           (done),
        .match_any      (match_any),
        .match_count    (match_count),
        .match_handle   (match_handle),
        .result_value   (result_value),
        .result_context (result_context)
    );

    ////////////////////
    // Cell row
    ////////////////////

    for (genvar i = 0; i < NUM_CELLS; i++) begin : g_cell
        memory_cell #(
            .HANDLE (cell_array_pkg::word_t'(i))
        ) cell_i (
            .clk            (clk),
            .reset          (reset),
            .cmd_valid      (cmd_valid),
            .cmd_op         (cmd_op),
            .cmd_index      (cmd_index),
            .cmd_value      (cmd_value),
            .cmd_metadata   (cmd_metadata),
            .cmd_meta_valid (cmd_meta_valid),
            .hit            (hits[i]),
            .res_value      (res_values[i*W +: W]),
            .res_context    (res_contexts[i*W +: W])
        );
    end

    match_reduce #(
        .NUM_CELLS (NUM_CELLS)
    ) reduce_i (
        .hits         (hits),
        .res_values   (res_values),
        .res_contexts (res_contexts),
        .red_any      (red_any),
        .red_count    (red_count),
        .red_handle   (red_handle),
        .red_value    (red_value),
        .red_context  (red_context)
    );

endmodule

//--- tb/cell_array_tb.sv
`timescale 1ns/1ps

module cell_array_tb;

    typedef cell_array_pkg::word_t word_t;
    typedef cell_array_pkg::op_t   op_t;

    localparam int CELLS          = 8;
    localparam int TIMEOUT_CYCLES = 3000;

    logic  clk;
    logic  reset;
    logic  start;
    op_t   op;
    word_t index;
    word_t value;
    word_t metadata;
    logic  meta_valid;
    logic  busy;
    logic  done;
    logic  match_any;
    word_t match_count;
    word_t match_handle;
    word_t result_value;
    word_t result_context;

    // Cell model
    logic  m_arr_def [CELLS];
    logic  m_elt_def [CELLS];
    word_t m_code    [CELLS];
    word_t m_rank    [CELLS];
    word_t m_low     [CELLS];
    word_t m_high    [CELLS];
    word_t m_index   [CELLS];
    word_t m_value   [CELLS];
    logic  m_hit     [CELLS];
    word_t m_rv      [CELLS];
    word_t m_rc      [CELLS];

    logic  exp_any;
    word_t exp_count;
    word_t exp_handle;
    word_t exp_value;
    word_t exp_context;

    string test_name;
    int    seed;
    int    cycle_count;
    int    issued;
    int    done_count;
    int    start_age;

    cell_array_top #(
        .NUM_CELLS (CELLS)
    ) dut_i (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .op             (op),
        .index          (index),
        .value          (value),
        .metadata       (metadata),
        .meta_valid     (meta_valid),
        .busy           (busy),
        .done           (done),
        .match_any      (match_any),
        .match_count    (match_count),
        .match_handle   (match_handle),
        .result_value   (result_value),
        .result_context (result_context)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input int expected, input int actual);
        abort_run($sformatf("CHECK FAILED [%s] %s: expected %0h, actual %0h",
                            test_name, field, expected, actual));
    endtask

    task automatic expect_word(input string field, input int expected, input int actual);
        assert (expected == actual) else report_mismatch(field, expected, actual);
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    task automatic model_apply(input op_t op_in, input word_t idx, input word_t val,
                               input word_t meta, input logic mv);
        word_t h;
        word_t nlow;
        word_t nhigh;
        logic  own;
        logic  in_rng;
        logic  old_arr;
        for (int c = 0; c < CELLS; c++) begin
            h      = word_t'(c);
            own    = (meta == h);
            in_rng = (m_low[c] <= meta) && (meta <= m_high[c]);
            case (op_in)
                cell_array_pkg::OP_UPDATE: begin
                    m_hit[c] = own && mv;
                    m_rv[c]  = h;
                    m_rc[c]  = h;
                    if (own && mv) begin
                        m_arr_def[c] = 1'b1;
                        m_elt_def[c] = 1'b1;
                        m_code[c]    = h;
                        m_low[c]     = h;
                        m_high[c]    = h;
                        m_index[c]   = idx;
                        m_value[c]   = val;
                        m_rank[c]    = 8'd1;
                    end
                end
                cell_array_pkg::OP_LOOKUP: begin
                    m_hit[c] = (m_index[c] == idx) && in_rng && mv;
                    m_rv[c]  = m_value[c];
                    m_rc[c]  = m_rank[c];
                end
                cell_array_pkg::OP_ENCODE: begin
                    m_hit[c] = mv && m_arr_def[c] && own;
                    m_rv[c]  = m_code[c];
                    m_rc[c]  = m_code[c];
                end
                cell_array_pkg::OP_CONGRUE_UP: begin
                    if (idx == h && mv) begin
                        m_code[c] = meta + 8'd1;
                        m_low[c]  = meta + 8'd1;
                        m_high[c] = meta + 8'd1;
                        m_rank[c] = val + 8'd1;
                    end else if (mv) begin
                        if (m_arr_def[c] && m_code[c] > meta)
                            m_code[c] = m_code[c] + 8'd1;
                        if (m_elt_def[c] && m_low[c] > meta)
                            m_low[c] = m_low[c] + 8'd1;
                        if (m_elt_def[c] && m_high[c] >= meta)
                            m_high[c] = m_high[c] + 8'd1;
                    end
                end
                cell_array_pkg::OP_CONGRUE_DOWN: begin
                    old_arr = m_arr_def[c];
                    nlow    = m_low[c];
                    nhigh   = m_high[c];
                    if (idx == h && mv) begin
                        m_arr_def[c] = 1'b0;
                        m_rank[c]    = 8'd0;
                    end
                    if (m_elt_def[c] && mv) begin
                        if (meta < m_low[c]) begin
                            nlow  = m_low[c] - 8'd1;
                            nhigh = m_high[c] - 8'd1;
                        end else if (in_rng) begin
                            nhigh = m_high[c] - 8'd1;
                        end
                    end
                    if (m_elt_def[c] && nlow > nhigh) begin
                        m_elt_def[c] = 1'b0;
                        m_arr_def[c] = 1'b0;
                    end
                    if (old_arr && mv && m_code[c] > meta)
                        m_code[c] = m_code[c] - 8'd1;
                    m_low[c]  = nlow;
                    m_high[c] = nhigh;
                end
                cell_array_pkg::OP_MARK_FREE: begin
                    m_hit[c] = !m_elt_def[c];
                    m_rv[c]  = h;
                    m_rc[c]  = h;
                end
                cell_array_pkg::OP_ENRANK: begin
                    m_hit[c] = mv && m_arr_def[c] && own;
                    m_rv[c]  = m_rank[c];
                    m_rc[c]  = m_rank[c];
                end
                default: begin
                    m_hit[c] = own;
                    m_rv[c]  = m_high[c] + 8'd1;
                end
            endcase
        end

        // Lowest matching handle wins
        exp_any     = 1'b0;
        exp_count   = 8'd0;
        exp_handle  = 8'd0;
        exp_value   = 8'd0;
        exp_context = 8'd0;
        for (int c = 0; c < CELLS; c++) begin
            if (m_hit[c]) begin
                if (!exp_any) begin
                    exp_handle  = word_t'(c);
                    exp_value   = m_rv[c];
                    exp_context = m_rc[c];
                end
                exp_any   = 1'b1;
                exp_count = exp_count + 8'd1;
            end
        end
    endtask

    // One command; poke raises start again while busy
    task automatic issue(input op_t op_in, input word_t idx, input word_t val,
                         input word_t meta, input logic mv, input logic poke);
        @(negedge clk);
        op         = op_in;
        index      = idx;
        value      = val;
        metadata   = meta;
        meta_valid = mv;
        start      = 1'b1;
        model_apply(op_in, idx, val, meta, mv);
        issued = issued + 1;
        @(negedge clk);
        start = poke;
        if (poke) begin
            op       = cell_array_pkg::OP_UPDATE;
            metadata = ~meta;
        end
        @(negedge clk);
        start = 1'b0;
        while (!done)
            @(negedge clk);
    endtask

    ////////////////////
    // Checkers
    ////////////////////

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run("Timeout: the run did not finish within the cycle limit");
    end

    always @(posedge clk) begin
        if (!reset)
            done_count <= 0;
        else if (done)
            done_count <= done_count + 1;
        if (!reset)
            start_age <= 0;
        else if (start && !busy)
            start_age <= 1;
        else if (start_age != 0 && start_age < 3)
            start_age <= start_age + 1;
        else
            start_age <= 0;
    end

    done_latency: assert property (@(posedge clk) disable iff (!reset)
        done |-> start_age == 3)
        else report_mismatch("done latency", 3, $sampled(start_age));
    done_due: assert property (@(posedge clk) disable iff (!reset)
        start_age == 3 |-> done) else report_mismatch("done", 1, $sampled(done));
    busy_level: assert property (@(posedge clk) disable iff (!reset)
        busy == (start_age == 1 || start_age == 2))
        else report_mismatch("busy", $sampled(start_age) == 1 || $sampled(start_age) == 2,
                             $sampled(busy));
    single_strobe: assert property (@(posedge clk) disable iff (!reset)
        dut_i.cmd_valid == (start_age == 1))
        else report_mismatch("cmd_valid", $sampled(start_age) == 1, $sampled(dut_i.cmd_valid));

    any_ok: assert property (@(posedge clk) disable iff (!reset)
        done |-> match_any == exp_any) else report_mismatch("match_any", exp_any, match_any);
    count_ok: assert property (@(posedge clk) disable iff (!reset)
        done |-> match_count == exp_count)
        else report_mismatch("match_count", exp_count, match_count);
    handle_ok: assert property (@(posedge clk) disable iff (!reset)
        done |-> match_handle == exp_handle)
        else report_mismatch("match_handle", exp_handle, match_handle);
    value_ok: assert property (@(posedge clk) disable iff (!reset)
        done |-> result_value == exp_value)
        else report_mismatch("result_value", exp_value, result_value);
    context_ok: assert property (@(posedge clk) disable iff (!reset)
        done |-> result_context == exp_context)
        else report_mismatch("result_context", exp_context, result_context);

    ////////////////////
    // Tests
    ////////////////////

    initial begin
        op_t   r_op;
        word_t r_idx;
        word_t r_val;
        word_t r_meta;
        logic  r_mv;
        reset       = 1'b0;
        start       = 1'b0;
        op          = '0;
        index       = '0;
        value       = '0;
        metadata    = '0;
        meta_valid  = 1'b0;
        seed        = 65;
        cycle_count = 0;
        issued      = 0;
        test_name   = "reset";
        for (int c = 0; c < CELLS; c++) begin
            m_arr_def[c] = 1'b0;
            m_elt_def[c] = 1'b0;
            m_code[c]    = '0;
            m_rank[c]    = '0;
            m_low[c]     = '0;
            m_high[c]    = '0;
            m_index[c]   = '0;
            m_value[c]   = '0;
            m_hit[c]     = 1'b0;
            m_rv[c]      = '0;
            m_rc[c]      = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        assert (!busy && !done) else abort_run("busy or done is high after reset");
        issue(cell_array_pkg::OP_MARK_FREE, 8'd0, 8'd0, 8'd0, 1'b0, 1'b0);
        expect_word("free count", 8, match_count);

        test_name = "timing";
        issue(cell_array_pkg::OP_DEBUG, 8'd0, 8'd0, 8'd5, 1'b1, 1'b1);
        issue(cell_array_pkg::OP_MARK_FREE, 8'd0, 8'd0, 8'd0, 1'b1, 1'b1);

        test_name = "update";
        issue(cell_array_pkg::OP_UPDATE, 8'h21, 8'h5a, 8'd3, 1'b1, 1'b0);
        issue(cell_array_pkg::OP_ENCODE, 8'd0, 8'd0, 8'd3, 1'b1, 1'b0);
        expect_word("encode", 3, result_value);
        issue(cell_array_pkg::OP_ENRANK, 8'd0, 8'd0, 8'd3, 1'b1, 1'b0);
        expect_word("enrank", 1, result_value);
        issue(cell_array_pkg::OP_LOOKUP, 8'h21, 8'd0, 8'd3, 1'b1, 1'b0);
        expect_word("lookup value", 8'h5a, result_value);
        expect_word("lookup handle", 3, match_handle);
        issue(cell_array_pkg::OP_MARK_FREE, 8'd0, 8'd0, 8'd0, 1'b1, 1'b0);
        expect_word("free after update", 7, match_count);

        test_name = "congrue";
        for (int h = 0; h < 5; h++)
            issue(cell_array_pkg::OP_UPDATE, word_t'(h + 16), word_t'(h), word_t'(h), 1'b1, 1'b0);
        issue(cell_array_pkg::OP_CONGRUE_UP, 8'd6, 8'd4, 8'd1, 1'b1, 1'b0);
        issue(cell_array_pkg::OP_CONGRUE_DOWN, 8'd0, 8'd0, 8'd0, 1'b1, 1'b0);
        issue(cell_array_pkg::OP_CONGRUE_DOWN, 8'd7, 8'd0, 8'd2, 1'b1, 1'b0);
        issue(cell_array_pkg::OP_CONGRUE_DOWN, 8'd7, 8'd0, 8'd2, 1'b1, 1'b0);
        for (int h = 0; h < CELLS; h++) begin
            issue(cell_array_pkg::OP_ENCODE, 8'd0, 8'd0, word_t'(h), 1'b1, 1'b0);
            issue(cell_array_pkg::OP_DEBUG, 8'd0, 8'd0, word_t'(h), 1'b1, 1'b0);
        end
        issue(cell_array_pkg::OP_MARK_FREE, 8'd0, 8'd0, 8'd0, 1'b1, 1'b0);

        test_name = "random";
        for (int n = 0; n < 200; n++) begin
            r_op   = op_t'($random(seed));
            r_idx  = word_t'($random(seed) & 7);
            r_val  = word_t'($random(seed));
            r_meta = word_t'($random(seed) & 7);
            r_mv   = ($random(seed) & 3) != 0;
            issue(r_op, r_idx, r_val, r_meta, r_mv, 1'b0);
        end

        @(negedge clk);
        @(negedge clk);
        if (done_count != issued) begin
            abort_run($sformatf("Done count %0d does not match %0d issued commands",
                                done_count, issued));
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- cell_array.f
hw/cell_array_pkg.sv
hw/memory_cell.sv
hw/match_reduce.sv
hw/command_sequencer.sv
hw/cell_array_top.sv
tb/cell_array_tb.sv

//--- Makefile
TOP := cell_array_tb

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f cell_array.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f cell_array.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
